// File: Makefile
VERILATOR ?= verilator
TOP       ?= lane_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/lane_props.sv
// Handshake properties of the vector lane
// Bound to the lane top level, watches the request, store and
// completion ports

`timescale 1ns/1ps
`default_nettype none

module lane_props (
  input wire             clk_i,
  input wire             rst_ni,
  input wire             req_valid_i,
  input wire             req_ready_o,
  input wire             store_valid_o,
  input wire             store_ready_i,
  input lane_pkg::elem_t store_data_o,
  input wire             done_valid_o
);

  // Number of failed properties
  int unsigned fail_cnt = 0;

  // Stalled store data holds until taken
  store_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_valid_o && !store_ready_i |=> store_valid_o && $stable(store_data_o))
    else begin
      $error("store_data_o changed or store_valid_o dropped while stalled");
      fail_cnt++;
    end

  // Request slots only fill on a transfer
  req_ready_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_ready_o && !req_valid_i |=> req_ready_o)
    else begin
      $error("req_ready_o fell without an accepted request");
      fail_cnt++;
    end

  // Outputs quiet while the lane is in reset
  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !store_valid_o && !done_valid_o)
    else begin
      $error("store_valid_o or done_valid_o high during reset");
      fail_cnt++;
    end

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_valid_o |=> !done_valid_o)
    else begin
      $error("done_valid_o held longer than one cycle");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// File: bench/lane_tb.sv
// Testbench for the vector lane
// Drives VID, ALU and store instructions, keeps a model of the
// register file and checks the store stream and completion ids

`timescale 1ns/1ps
`default_nettype none

module lane_tb;
  import lane_pkg::*;

  localparam int unsigned NrElems   = 8;
  localparam int unsigned NrRandom  = 40;
  // Instructions over all tests, sizes the watchdog
  localparam int unsigned NrInsn    = 2 + 16 + NrRandom;
  localparam int unsigned ClkPeriod = 4;

  logic     clk_i, rst_ni;
  logic     req_valid_i, req_ready_o;
  vid_t     req_id_i;
  lane_op_e req_op_i;
  vreg_t    req_vd_i, req_vs1_i, req_vs2_i;
  elem_t    req_scalar_i;
  logic     store_valid_o, store_ready_i;
  elem_t    store_data_o;
  logic     done_valid_o;
  vid_t     done_id_o;

  elem_t model_vrf [NR_VREGS][NrElems];
  elem_t exp_store [$];
  vid_t  exp_done [$];
  vid_t  next_id;
  int    seed, bp_seed;
  logic  bp_on;
  int    checks, errors, test_base;

  lane #(.NrElems(NrElems)) dut0 (.*);

  bind lane lane_props i_props (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
    .store_valid_o(store_valid_o), .store_ready_i(store_ready_i),
    .store_data_o(store_data_o), .done_valid_o(done_valid_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Store sink, random stalls while back-pressure is on
  always @(posedge clk_i) begin
    #1;
    store_ready_i = bp_on ? 1'($random(bp_seed)) : 1'b1;
  end

  //////////////////////////////////////////////////
  // Monitor, mid-cycle where outputs are settled
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni && store_valid_o && store_ready_i) begin
      checks++;
      assert (exp_store.size() != 0) else begin
        $display("Unexpected store transfer at %0t ns", $time);
        errors++;
      end
      if (exp_store.size() != 0) begin
        assert (store_data_o == exp_store[0]) else begin
          $display("[FAIL] %0t ns store_data_o: got %h, expected %h",
                   $time, store_data_o, exp_store[0]);
          errors++;
        end
        void'(exp_store.pop_front());
      end
    end
    if (rst_ni && done_valid_o) begin
      checks++;
      assert (exp_done.size() != 0) else begin
        $display("Unexpected completion at %0t ns, id %0d", $time, done_id_o);
        errors++;
      end
      if (exp_done.size() != 0) begin
        assert (done_id_o == exp_done[0]) else begin
          $display("[FAIL] %0t ns done_id_o: got %0d, expected %0d",
                   $time, done_id_o, exp_done[0]);
          errors++;
        end
        void'(exp_done.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////
  // Reference model and request driver
  //////////////////////////////////////////////////

  // Element i of a VID is scalar + i; a store streams vs2 in order
  task automatic update_model(lane_op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2,
                              elem_t scalar);
    elem_t a, b;
    for (int i = 0; i < NrElems; i++) begin
      a = model_vrf[vs1][i];
      b = model_vrf[vs2][i];
      case (op)
        OP_VID:  model_vrf[vd][i] = scalar + elem_t'(i);
        OP_VADD: model_vrf[vd][i] = b + a;
        OP_VSUB: model_vrf[vd][i] = b - a;
        OP_VAND: model_vrf[vd][i] = a & b;
        OP_VXOR: model_vrf[vd][i] = a ^ b;
        default: exp_store.push_back(b);
      endcase
    end
    exp_done.push_back(next_id);
  endtask

  task automatic send(lane_op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, elem_t scalar);
    logic acc;
    update_model(op, vd, vs1, vs2, scalar);
    req_valid_i  = 1'b1;
    req_id_i     = next_id;
    req_op_i     = op;
    req_vd_i     = vd;
    req_vs1_i    = vs1;
    req_vs2_i    = vs2;
    req_scalar_i = scalar;
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk_i);
      acc = req_ready_o;
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
    next_id     = next_id + 1'b1;
  endtask

  task automatic wait_idle();
    do begin
      @(posedge clk_i);
      #1;
    end while (exp_store.size() != 0 || exp_done.size() != 0);
  endtask

  task automatic report_test(string name);
    $display("Test %s finished with %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic check_reset();
    int cycles;
    cycles = 0;
    repeat (5) begin
      @(negedge clk_i);
      checks++;
      assert (!store_valid_o && !done_valid_o) else begin
        $display("[FAIL] %0t ns store_valid_o/done_valid_o: got %b/%b, expected 0/0",
                 $time, store_valid_o, done_valid_o);
        errors++;
      end
      @(posedge clk_i);
    end
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    while (!req_ready_o && cycles < 10) begin
      @(negedge clk_i);
      cycles++;
    end
    checks++;
    assert (req_ready_o) else begin
      $display("req_ready_o did not rise within 10 cycles after reset");
      errors++;
    end
    @(posedge clk_i);
    #1;
    report_test("reset");
  endtask

  task automatic run_vid_store();
    send(OP_VID, 3'd1, 3'd0, 3'd0, elem_t'($random(seed)));
    send(OP_VSTORE, 3'd0, 3'd0, 3'd1, '0);
    wait_idle();
    report_test("vid_store");
  endtask

  task automatic run_alu();
    for (int r = 0; r < NR_VREGS; r++) begin
      send(OP_VID, vreg_t'(r), 3'd0, 3'd0, elem_t'($random(seed)));
    end
    send(OP_VADD, 3'd4, 3'd2, 3'd3, '0);
    send(OP_VSTORE, 3'd0, 3'd0, 3'd4, '0);
    send(OP_VSUB, 3'd5, 3'd2, 3'd3, '0);
    send(OP_VSTORE, 3'd0, 3'd0, 3'd5, '0);
    send(OP_VAND, 3'd7, 3'd0, 3'd1, '0);
    send(OP_VSTORE, 3'd0, 3'd0, 3'd7, '0);
    // Destination overwrites its own first source
    send(OP_VXOR, 3'd6, 3'd6, 3'd1, '0);
    send(OP_VSTORE, 3'd0, 3'd0, 3'd6, '0);
    wait_idle();
    report_test("alu");
  endtask

  task automatic run_random();
    logic [2:0] op_sel;
    int         gap;
    @(negedge clk_i);
    bp_on = 1'b1;
    @(posedge clk_i);
    #1;
    repeat (NrRandom) begin
      op_sel = 3'($unsigned($random(seed)) % 6);
      gap    = $unsigned($random(seed)) % 4;
      send(lane_op_e'(op_sel), vreg_t'($random(seed)), vreg_t'($random(seed)),
           vreg_t'($random(seed)), elem_t'($random(seed)));
      repeat (gap) begin
        @(posedge clk_i);
        #1;
      end
    end
    wait_idle();
    bp_on = 1'b0;
    report_test("random");
  endtask

  initial begin
    int prop_fails;
    clk_i         = 1'b0;
    rst_ni        = 1'b1;
    req_valid_i   = 1'b0;
    req_id_i      = '0;
    req_op_i      = OP_VID;
    req_vd_i      = '0;
    req_vs1_i     = '0;
    req_vs2_i     = '0;
    req_scalar_i  = '0;
    store_ready_i = 1'b1;
    seed          = 32'he3d0_90e9;
    bp_seed       = seed ^ 32'h0000_ffff;
    bp_on         = 1'b0;
    next_id       = '0;
    checks        = 0;
    errors        = 0;
    test_base     = 0;
    #1 rst_ni = 1'b0;
    check_reset();
    run_vid_store();
    run_alu();
    run_random();
    prop_fails = dut0.i_props.fail_cnt;
    $display("Checks: %0d, errors: %0d, property failures: %0d", checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((NrInsn * (NrElems + 10) * 8 + 20) * ClkPeriod);
    $display("Timeout: the lane did not finish all tests in time");
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hdl/lane_pkg.sv
hdl/lane_op_if.sv
hdl/lane_spill_reg.sv
hdl/lane_decode.sv
hdl/lane_regfile.sv
hdl/lane_execute.sv
hdl/lane_result.sv
hdl/lane.sv
bench/lane_props.sv
bench/lane_tb.sv

// File: hdl/lane.sv
// Vector lane top level
// Request spill register, sequencer, VRF slice, execute and result
// stages, and a spill register on the store operand stream

`timescale 1ns/1ps
`default_nettype none

module lane #(
  parameter int unsigned NrElems = 8
) (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  input  wire                 req_valid_i,
  output logic                req_ready_o,
  input  lane_pkg::vid_t      req_id_i,
  input  lane_pkg::lane_op_e  req_op_i,
  input  lane_pkg::vreg_t     req_vd_i,
  input  lane_pkg::vreg_t     req_vs1_i,
  input  lane_pkg::vreg_t     req_vs2_i,
  input  lane_pkg::elem_t     req_scalar_i,
  output logic                store_valid_o,
  input  wire                 store_ready_i,
  output lane_pkg::elem_t     store_data_o,
  output logic                done_valid_o,
  output lane_pkg::vid_t      done_id_o
);
  import lane_pkg::*;

  localparam int unsigned IdxW = $clog2(NrElems);

  vinsn_t          req_insn, dec_insn;
  logic            dec_valid, dec_ready, retire;
  vreg_t           rd_a_reg, rd_b_reg, wr_reg;
  logic [IdxW-1:0] rd_elem, wr_elem;
  elem_t           rd_a, rd_b, wr_data, st_data;
  logic            wr_en, res_valid, res_ready, st_valid, st_ready;
  res_elem_t       res;

  lane_op_if #(.NrElems(NrElems)) op_if ();

  assign req_insn = '{id: req_id_i, op: req_op_i, vd: req_vd_i, vs1: req_vs1_i,
                      vs2: req_vs2_i, scalar: req_scalar_i};

  ////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////

  lane_spill_reg #(.T(vinsn_t)) i_req_spill (
    .clk_i, .rst_ni,
    .valid_i(req_valid_i), .ready_o(req_ready_o), .data_i(req_insn),
    .valid_o(dec_valid),   .ready_i(dec_ready),   .data_o(dec_insn)
  );

  lane_decode #(.NrElems(NrElems)) i_decode (
    .clk_i, .rst_ni,
    .insn_valid_i(dec_valid), .insn_ready_o(dec_ready), .insn_i(dec_insn),
    .op_o(op_if.dec), .retire_i(retire)
  );

  ////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////

  lane_regfile #(.NrElems(NrElems)) i_vrf (
    .clk_i, .rst_ni,
    .rd_a_reg_i(rd_a_reg), .rd_b_reg_i(rd_b_reg), .rd_elem_i(rd_elem),
    .rd_a_o(rd_a), .rd_b_o(rd_b),
    .wr_en_i(wr_en), .wr_reg_i(wr_reg), .wr_elem_i(wr_elem), .wr_data_i(wr_data)
  );

  lane_execute #(.NrElems(NrElems)) i_execute (
    .clk_i, .rst_ni, .op_i(op_if.exe),
    .rd_a_reg_o(rd_a_reg), .rd_b_reg_o(rd_b_reg), .rd_elem_o(rd_elem),
    .rd_a_i(rd_a), .rd_b_i(rd_b),
    .res_valid_o(res_valid), .res_ready_i(res_ready), .res_o(res)
  );

  ////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////

  lane_result #(.NrElems(NrElems)) i_result (
    .clk_i, .rst_ni,
    .res_valid_i(res_valid), .res_ready_o(res_ready), .res_i(res),
    .wr_en_o(wr_en), .wr_reg_o(wr_reg), .wr_elem_o(wr_elem), .wr_data_o(wr_data),
    .st_valid_o(st_valid), .st_ready_i(st_ready), .st_data_o(st_data),
    .retire_o(retire), .done_valid_o(done_valid_o), .done_id_o(done_id_o)
  );

  lane_spill_reg #(.T(elem_t)) i_store_spill (
    .clk_i, .rst_ni,
    .valid_i(st_valid),      .ready_o(st_ready),      .data_i(st_data),
    .valid_o(store_valid_o), .ready_i(store_ready_i), .data_o(store_data_o)
  );

endmodule

`default_nettype wire

// File: hdl/lane_decode.sv
// Lane sequencer
// Takes one vector instruction at a time and issues its elements in
// order, one per cycle. A new instruction waits until every issued
// element has retired, which keeps reads behind earlier writes

`timescale 1ns/1ps
`default_nettype none

module lane_decode #(
  parameter int unsigned NrElems = 8
) (
  input  wire              clk_i,
  input  wire              rst_ni,
  input  wire              insn_valid_i,
  output logic             insn_ready_o,
  input  lane_pkg::vinsn_t insn_i,
  lane_op_if.dec           op_o,
  input  wire              retire_i
);
  import lane_pkg::*;

  localparam int unsigned IdxW = $clog2(NrElems);
  localparam int unsigned CntW = $clog2(NrElems) + 1;

  logic            busy_q;
  vinsn_t          insn_q;
  logic [IdxW-1:0] elem_q;
  logic [CntW-1:0] inflight_q, inflight_d;
  logic            accept, issue, last_elem;

  assign insn_ready_o = ~busy_q & (inflight_q == '0);
  assign accept       = insn_valid_i & insn_ready_o;
  assign issue        = op_o.valid & op_o.ready;
  assign last_elem    = elem_q == IdxW'(NrElems - 1);

  assign op_o.valid = busy_q;
  assign op_o.insn  = insn_q;
  assign op_o.elem  = elem_q;
  assign op_o.last  = last_elem;

  // Elements issued but not yet written back or streamed out
  always_comb begin
    inflight_d = inflight_q;
    if (issue && !retire_i) begin
      inflight_d = inflight_q + 1'b1;
    end else if (!issue && retire_i) begin
      inflight_d = inflight_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      elem_q     <= '0;
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_d;
      if (accept) begin
        busy_q <= 1'b1;
        elem_q <= '0;
      end else if (issue) begin
        elem_q <= elem_q + 1'b1;
        if (last_elem) busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) insn_q <= insn_i;
  end

endmodule

`default_nettype wire

// File: hdl/lane_execute.sv
// Execute stage
// Stage one captures the element op and its two register operands,
// stage two holds the ALU result until write-back accepts it

`timescale 1ns/1ps
`default_nettype none

module lane_execute #(
  parameter int unsigned NrElems = 8
) (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  lane_op_if.exe                     op_i,
  output lane_pkg::vreg_t            rd_a_reg_o,
  output lane_pkg::vreg_t            rd_b_reg_o,
  output logic [$clog2(NrElems)-1:0] rd_elem_o,
  input  lane_pkg::elem_t            rd_a_i,
  input  lane_pkg::elem_t            rd_b_i,
  output logic                       res_valid_o,
  input  wire                        res_ready_i,
  output lane_pkg::res_elem_t        res_o
);
  import lane_pkg::*;

  logic                       s1_valid_q, s2_valid_q;
  vinsn_t                     s1_insn_q;
  logic [$clog2(NrElems)-1:0] s1_elem_q;
  logic                       s1_last_q;
  elem_t                      s1_a_q, s1_b_q;
  res_elem_t                  s2_res_q;
  elem_t                      alu_res;
  logic                       advance;

  // Operand addresses go straight from the op channel to the VRF
  assign rd_a_reg_o = op_i.insn.vs1;
  assign rd_b_reg_o = op_i.insn.vs2;
  assign rd_elem_o  = op_i.elem;

  // Whole pipe moves whenever the output slot is free or draining
  assign advance    = ~s2_valid_q | res_ready_i;
  assign op_i.ready = advance;

  ////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////

  always_comb begin
    alu_res = s1_b_q;
    unique case (s1_insn_q.op)
      OP_VID:  alu_res = s1_insn_q.scalar + elem_t'(s1_elem_q);
      OP_VADD: alu_res = s1_a_q + s1_b_q;
      OP_VSUB: alu_res = s1_b_q - s1_a_q;
      OP_VAND: alu_res = s1_a_q & s1_b_q;
      OP_VXOR: alu_res = s1_a_q ^ s1_b_q;
      default: alu_res = s1_b_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= op_i.valid;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_insn_q <= op_i.insn;
      s1_elem_q <= op_i.elem;
      s1_last_q <= op_i.last;
      s1_a_q    <= rd_a_i;
      s1_b_q    <= rd_b_i;
      s2_res_q  <= '{store: s1_insn_q.op == OP_VSTORE, vd: s1_insn_q.vd,
                     value: alu_res, last: s1_last_q, id: s1_insn_q.id};
    end
  end

  assign res_valid_o = s2_valid_q;
  assign res_o       = s2_res_q;

endmodule

`default_nettype wire

// File: hdl/lane_op_if.sv
// Element operation channel from the lane sequencer to execute
// Carries the instruction, the element index and a last flag

`timescale 1ns/1ps
`default_nettype none

interface lane_op_if #(
  parameter int unsigned NrElems = 8
);
  import lane_pkg::*;

  logic                       valid;
  logic                       ready;
  vinsn_t                     insn;
  logic [$clog2(NrElems)-1:0] elem;
  logic                       last;

  modport dec (output valid, insn, elem, last, input ready);
  modport exe (input valid, insn, elem, last, output ready);

endinterface

`default_nettype wire

// File: hdl/lane_pkg.sv
// Vector lane package
// Element width, register file size, opcodes and the request and
// result element types shared by the lane stages

`default_nettype none

package lane_pkg;

  // Datapath width of one element
  localparam int unsigned ELEN     = 32;
  localparam int unsigned NR_VREGS = 8;

  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;
  typedef logic [3:0]                  vid_t;
  typedef logic [ELEN-1:0]             elem_t;

  typedef enum logic [2:0] {
    OP_VID    = 3'd0,
    OP_VADD   = 3'd1,
    OP_VSUB   = 3'd2,
    OP_VAND   = 3'd3,
    OP_VXOR   = 3'd4,
    OP_VSTORE = 3'd5
  } lane_op_e;

  // One whole vector instruction
  typedef struct packed {
    vid_t     id;
    lane_op_e op;
    vreg_t    vd;
    vreg_t    vs1;
    vreg_t    vs2;
    elem_t    scalar;
  } vinsn_t;

  // Element leaving the ALU towards write-back or the store stream
  typedef struct packed {
    logic  store;
    vreg_t vd;
    elem_t value;
    logic  last;
    vid_t  id;
  } res_elem_t;

endpackage

`default_nettype wire

// File: hdl/lane_regfile.sv
// Lane slice of the vector register file
// NR_VREGS registers of NrElems elements each, with two combinational
// read ports and one synchronous write port

`timescale 1ns/1ps
`default_nettype none

module lane_regfile #(
  parameter int unsigned NrElems = 8
) (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  lane_pkg::vreg_t            rd_a_reg_i,
  input  lane_pkg::vreg_t            rd_b_reg_i,
  input  wire [$clog2(NrElems)-1:0]  rd_elem_i,
  output lane_pkg::elem_t            rd_a_o,
  output lane_pkg::elem_t            rd_b_o,
  input  wire                        wr_en_i,
  input  lane_pkg::vreg_t            wr_reg_i,
  input  wire [$clog2(NrElems)-1:0]  wr_elem_i,
  input  lane_pkg::elem_t            wr_data_i
);
  import lane_pkg::*;

  elem_t mem [NR_VREGS][NrElems];

  ////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////

  assign rd_a_o = mem[rd_a_reg_i][rd_elem_i];
  assign rd_b_o = mem[rd_b_reg_i][rd_elem_i];

  ////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////

  // Writes are ignored while the lane is held in reset
  always_ff @(posedge clk_i) begin
    if (rst_ni && wr_en_i) begin
      mem[wr_reg_i][wr_elem_i] <= wr_data_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/lane_result.sv
// Result stage
// Sends each element to a VRF write or to the store stream, strobes
// the sequencer on retirement and reports instruction completion

`timescale 1ns/1ps
`default_nettype none

module lane_result #(
  parameter int unsigned NrElems = 8
) (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        res_valid_i,
  output logic                       res_ready_o,
  input  lane_pkg::res_elem_t        res_i,
  output logic                       wr_en_o,
  output lane_pkg::vreg_t            wr_reg_o,
  output logic [$clog2(NrElems)-1:0] wr_elem_o,
  output lane_pkg::elem_t            wr_data_o,
  output logic                       st_valid_o,
  input  wire                        st_ready_i,
  output lane_pkg::elem_t            st_data_o,
  output logic                       retire_o,
  output logic                       done_valid_o,
  output lane_pkg::vid_t             done_id_o
);
  import lane_pkg::*;

  logic [$clog2(NrElems)-1:0] elem_q;
  logic                       accept;
  logic                       done_q;
  vid_t                       done_id_q;

  // Writes never stall, stores wait on the store spill register
  assign res_ready_o = ~res_i.store | st_ready_i;
  assign accept      = res_valid_i & res_ready_o;
  assign retire_o    = accept;

  assign wr_en_o    = res_valid_i & ~res_i.store;
  assign wr_reg_o   = res_i.vd;
  assign wr_elem_o  = elem_q;
  assign wr_data_o  = res_i.value;
  assign st_valid_o = res_valid_i & res_i.store;
  assign st_data_o  = res_i.value;

  // Elements arrive in order, so the index is rebuilt here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      elem_q <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= accept & res_i.last;
      if (accept) elem_q <= res_i.last ? '0 : elem_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && res_i.last) done_id_q <= res_i.id;
  end

  assign done_valid_o = done_q;
  assign done_id_o    = done_id_q;

endmodule

`default_nettype wire

// File: hdl/lane_spill_reg.sv
// Two-entry spill register on a valid/ready channel
// Both valid and ready leave the block from flops, so no
// combinational path crosses it in either direction

`timescale 1ns/1ps
`default_nettype none

module lane_spill_reg #(
  parameter type T = logic
) (
  input  wire  clk_i,
  input  wire  rst_ni,
  input  wire  valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  wire  ready_i,
  output T     data_o
);

  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i & ready_o;
  // Slot A empties every cycle B is free, either downstream or into B
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  // B always holds the older entry
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

`default_nettype wire
